//--- hdl/agen_defs.svh
// address generation stage widths and counts
// shared by the package and every RTL block of the stage

`ifndef AGEN_DEFS_SVH
`define AGEN_DEFS_SVH

// general register width
`define AGEN_GPR_W 32

// operand width, wide enough for an MMX register
`define AGEN_OP_W 64

// segment register width
`define AGEN_SEG_W 16

// zero-extended immediate
`define AGEN_IMM_W 48

// opcode carried down the pipe
`define AGEN_OPC_W 16

// registers per file, GPR and MMX alike
`define AGEN_NUM_REGS 8

// real-mode segment base is seg << 4
`define AGEN_SEG_SHIFT 4

`endif

//--- hdl/agen_pkg.sv
// address generation package
// operand source and size codes, register file views and stage payloads

`include "agen_defs.svh"

package agen_pkg;

    // six segment registers, indices 6 and 7 read zero
    localparam int NUM_SEGS = 6;

    // string instruction index registers
    localparam int GPR_ESI = 6;
    localparam int GPR_EDI = 7;

    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_REG   = 3'd1,
        OP_SEG   = 3'd2,
        OP_MMX   = 3'd3,
        OP_MODRM = 3'd4,
        OP_IMM   = 3'd5,
        OP_MEM   = 3'd6,
        OP_SYS   = 3'd7
    } op_src_e;

    // codes not listed select no register at all
    typedef enum logic [2:0] {
        SZ_8  = 3'd1,
        SZ_16 = 3'd2,
        SZ_32 = 3'd3,
        SZ_64 = 3'd5
    } op_size_e;

    typedef enum logic [2:0] {
        ES = 3'd0,
        CS = 3'd1,
        SS = 3'd2,
        DS = 3'd3,
        FS = 3'd4,
        GS = 3'd5
    } seg_idx_e;

    // index 0 is EAX, in x86 encoding order
    typedef logic [`AGEN_NUM_REGS-1:0][`AGEN_GPR_W-1:0] gpr_file_t;
    typedef logic [NUM_SEGS-1:0][`AGEN_SEG_W-1:0] seg_file_t;
    typedef logic [`AGEN_NUM_REGS-1:0][`AGEN_OP_W-1:0] mmx_file_t;
    typedef logic [`AGEN_NUM_REGS-1:0][`AGEN_OP_W-1:0] sized_regs_t;

    typedef struct packed {
        op_size_e                size;
        op_src_e                 op0_src;
        op_src_e                 op1_src;
        logic [2:0]              op0_reg;
        logic [2:0]              op1_reg;
        seg_idx_e                seg_override;
        logic                    seg_override_valid;
        logic [`AGEN_IMM_W-1:0]  imm;
        logic [3:0]              alu_op;
        logic [`AGEN_GPR_W-1:0]  pc;
        logic [`AGEN_OPC_W-1:0]  opcode;
    } agen_req_t;

    typedef struct packed {
        logic [`AGEN_OP_W-1:0]   value;
        logic                    is_address;
    } operand_t;

    typedef struct packed {
        op_size_e                size;
        operand_t                op0;
        operand_t                op1;
        logic [2:0]              op0_reg;
        logic [2:0]              op1_reg;
        logic [`AGEN_IMM_W-1:0]  imm;
        logic [3:0]              alu_op;
        logic [`AGEN_GPR_W-1:0]  pc;
        logic [`AGEN_OPC_W-1:0]  opcode;
        logic                    to_sys_controller;
    } agen_out_t;

endpackage

//--- hdl/reg_size_select.sv
// register size selector
// builds the eight zero-extended register views for the current operand size,
// shared by both operand generators

`include "agen_defs.svh"

module reg_size_select (
    input  agen_pkg::op_size_e    size,
    input  agen_pkg::gpr_file_t   gpr,
    input  agen_pkg::mmx_file_t   mmx,
    output agen_pkg::sized_regs_t sized
);

    always_comb begin
        for (int i = 0; i < `AGEN_NUM_REGS; i++) begin
            // zero unless a valid size picks something
            sized[i] = '0;
            case (size)
                agen_pkg::SZ_8: begin
                    // AL CL DL BL then AH CH DH BH
                    sized[i][7:0] = gpr[i % 4][(i / 4) * 8 +: 8];
                end
                agen_pkg::SZ_16: begin
                    sized[i][15:0] = gpr[i][15:0];
                end
                agen_pkg::SZ_32: begin
                    sized[i][`AGEN_GPR_W-1:0] = gpr[i];
                end
                agen_pkg::SZ_64: begin
                    // 64-bit operands come from the MMX file
                    sized[i] = mmx[i];
                end
                default: begin
                    sized[i] = '0;
                end
            endcase
        end
    end

endmodule

//--- hdl/dest_operand_gen.sv
// operand 0 generator
// selects the destination operand by source code, string form uses ES:EDI

`include "agen_defs.svh"

module dest_operand_gen (
    input  agen_pkg::agen_req_t   req,
    input  agen_pkg::sized_regs_t sized,
    input  agen_pkg::seg_file_t   seg,
    input  agen_pkg::mmx_file_t   mmx,
    input  logic [`AGEN_GPR_W-1:0] edi,
    output agen_pkg::operand_t    op0
);

    logic [`AGEN_SEG_W-1:0] seg_val;
    logic [`AGEN_GPR_W-1:0] es_base;
    logic [`AGEN_GPR_W-1:0] mem_addr;

    // segment indices past GS read as zero
    assign seg_val = (req.op0_reg < agen_pkg::NUM_SEGS) ? seg[req.op0_reg] : '0;

    // ES is never overridden for the destination string
    assign es_base = {{(`AGEN_GPR_W - `AGEN_SEG_W){1'b0}}, seg[agen_pkg::ES]};
    assign mem_addr = (es_base << `AGEN_SEG_SHIFT) + edi;

    always_comb begin
        op0.value = '0;
        case (req.op0_src)
            agen_pkg::OP_REG: begin
                op0.value = sized[req.op0_reg];
            end
            agen_pkg::OP_SEG: begin
                op0.value[`AGEN_SEG_W-1:0] = seg_val;
            end
            agen_pkg::OP_MMX: begin
                op0.value = mmx[req.op0_reg];
            end
            agen_pkg::OP_IMM: begin
                op0.value[`AGEN_IMM_W-1:0] = req.imm;
            end
            agen_pkg::OP_MEM: begin
                op0.value[`AGEN_GPR_W-1:0] = mem_addr;
            end
            default: begin
                // none, mod r/m and system give zero
                op0.value = '0;
            end
        endcase
    end

    // the destination is never read from memory here
    assign op0.is_address = 1'b0;

endmodule

//--- hdl/src_operand_gen.sv
// operand 1 generator
// selects the source operand by source code, string form uses DS:ESI
// or the override segment, and flags memory sources as addresses

`include "agen_defs.svh"

module src_operand_gen (
    input  agen_pkg::agen_req_t   req,
    input  agen_pkg::sized_regs_t sized,
    input  agen_pkg::seg_file_t   seg,
    input  agen_pkg::mmx_file_t   mmx,
    input  logic [`AGEN_GPR_W-1:0] esi,
    output agen_pkg::operand_t    op1
);

    logic [`AGEN_SEG_W-1:0] seg_val;
    logic [`AGEN_SEG_W-1:0] ovr_seg;
    logic [`AGEN_SEG_W-1:0] str_seg;
    logic [`AGEN_GPR_W-1:0] str_base;
    logic [`AGEN_GPR_W-1:0] mem_addr;

    // plain segment operand
    assign seg_val = (req.op1_reg < agen_pkg::NUM_SEGS) ? seg[req.op1_reg] : '0;

    // override segment, indices 6 and 7 read zero
    assign ovr_seg = (req.seg_override < agen_pkg::NUM_SEGS) ?
                     seg[req.seg_override] : '0;

    // DS unless a valid override replaces it
    assign str_seg = req.seg_override_valid ? ovr_seg : seg[agen_pkg::DS];

    assign str_base = {{(`AGEN_GPR_W - `AGEN_SEG_W){1'b0}}, str_seg};

    // wraps at 32 bits
    assign mem_addr = (str_base << `AGEN_SEG_SHIFT) + esi;

    always_comb begin
        op1.value = '0;
        case (req.op1_src)
            agen_pkg::OP_REG: begin
                op1.value = sized[req.op1_reg];
            end
            agen_pkg::OP_SEG: begin
                op1.value[`AGEN_SEG_W-1:0] = seg_val;
            end
            agen_pkg::OP_MMX: begin
                op1.value = mmx[req.op1_reg];
            end
            agen_pkg::OP_IMM: begin
                op1.value[`AGEN_IMM_W-1:0] = req.imm;
            end
            agen_pkg::OP_MEM: begin
                op1.value[`AGEN_GPR_W-1:0] = mem_addr;
            end
            default: begin
                op1.value = '0;
            end
        endcase
    end

    // memory stage reads the source through this address
    assign op1.is_address = (req.op1_src == agen_pkg::OP_MEM);

endmodule

//--- hdl/agen_pipe_reg.sv
// address generation pipeline register
// one-deep valid/ready stage holding the finished operands and pass-through
// fields, emptied by reset or flush

module agen_pipe_reg (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                in_valid,
    output logic                in_ready,
    input  agen_pkg::agen_req_t req,
    input  agen_pkg::operand_t  op0,
    input  agen_pkg::operand_t  op1,
    output logic                out_valid,
    input  logic                out_ready,
    output agen_pkg::agen_out_t out
);

    logic                full;
    logic                load;
    agen_pkg::agen_out_t data;

    // accept when empty or when the held item leaves this cycle
    assign in_ready = !full || out_ready;
    assign load     = in_valid && in_ready;

    // valid bit
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    // payload only moves on an accepted transfer, so it holds under stall
    always_ff @(posedge clk) begin
        if (load) begin
            data.size    <= req.size;
            data.op0     <= op0;
            data.op1     <= op1;
            data.op0_reg <= req.op0_reg;
            data.op1_reg <= req.op1_reg;
            data.imm     <= req.imm;
            data.alu_op  <= req.alu_op;
            data.pc      <= req.pc;
            data.opcode  <= req.opcode;
            // system micro-ops go to the controller with their own item
            data.to_sys_controller <= (req.op0_src == agen_pkg::OP_SYS);
        end
    end

    assign out_valid = full;
    assign out       = data;

endmodule

//--- hdl/address_generation_top.sv
// address generation stage top
// builds both operands from the register snapshot and registers them
// with the micro-op for the memory stage

module address_generation_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush,

    // from register access stage
    input  logic                  r_valid,
    output logic                  r_ready,
    input  agen_pkg::agen_req_t   r_req,
    input  agen_pkg::gpr_file_t   r_gpr,
    input  agen_pkg::seg_file_t   r_seg,
    input  agen_pkg::mmx_file_t   r_mmx,

    // to memory stage
    output logic                  a_valid,
    input  logic                  a_ready,
    output agen_pkg::agen_out_t   a_out
);

    agen_pkg::sized_regs_t sized;
    agen_pkg::operand_t    op0;
    agen_pkg::operand_t    op1;

    reg_size_select reg_size_select_inst (
        .size  (r_req.size),
        .gpr   (r_gpr),
        .mmx   (r_mmx),
        .sized (sized)
    );

    dest_operand_gen dest_operand_gen_inst (
        .req   (r_req),
        .sized (sized),
        .seg   (r_seg),
        .mmx   (r_mmx),
        .edi   (r_gpr[agen_pkg::GPR_EDI]),
        .op0   (op0)
    );

    src_operand_gen src_operand_gen_inst (
        .req   (r_req),
        .sized (sized),
        .seg   (r_seg),
        .mmx   (r_mmx),
        .esi   (r_gpr[agen_pkg::GPR_ESI]),
        .op1   (op1)
    );

    agen_pipe_reg agen_pipe_reg_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (r_valid),
        .in_ready  (r_ready),
        .req       (r_req),
        .op0       (op0),
        .op1       (op1),
        .out_valid (a_valid),
        .out_ready (a_ready),
        .out       (a_out)
    );

endmodule

//--- testbench/tb_clock.sv
// testbench clock source
// free-running clock with a 4 ns period

module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

//--- testbench/tb_address_generation.sv
// address generation stage testbench
// random micro-ops and register snapshots, a queue reference model and
// concurrent assertions on the output item and the handshake

module tb_address_generation;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ITEMS = 400;
    localparam int MAX_CYCLES = 4000;

    logic clk;
    logic rst_n;
    logic flush;
    logic r_valid;
    logic r_ready;
    agen_pkg::agen_req_t r_req;
    agen_pkg::gpr_file_t r_gpr;
    agen_pkg::seg_file_t r_seg;
    agen_pkg::mmx_file_t r_mmx;
    logic a_valid;
    logic a_ready;
    agen_pkg::agen_out_t a_out;

    integer seed = 99;
    int accepted = 0;

    // reference model state
    agen_pkg::agen_out_t model_q[$];
    agen_pkg::agen_out_t exp_head = '0;
    int exp_cnt = 0;
    logic acc_d = 1'b0;
    logic stall_d = 1'b0;
    logic rst_d = 1'b0;
    agen_pkg::agen_out_t prev_out = '0;
    logic out_chk;

    tb_clock tb_clock_inst (.clk(clk));

    address_generation_top address_generation_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush   (flush),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .r_req   (r_req),
        .r_gpr   (r_gpr),
        .r_seg   (r_seg),
        .r_mmx   (r_mmx),
        .a_valid (a_valid),
        .a_ready (a_ready),
        .a_out   (a_out)
    );

    task automatic stop_with_error(string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, logic [255:0] got, logic [255:0] exp);
        stop_with_error($sformatf("FAIL %s got %0h expected %0h", name, got, exp));
    endtask

    // AL..BL then AH..BH for byte size and the MMX file for 64 bits
    function automatic logic [63:0] sized_view(agen_pkg::op_size_e size, logic [2:0] idx,
            agen_pkg::gpr_file_t gpr, agen_pkg::mmx_file_t mmx);
        logic [63:0] v;
        v = '0;
        case (size)
            agen_pkg::SZ_8: v[7:0] = idx[2] ? gpr[idx[1:0]][15:8] : gpr[idx[1:0]][7:0];
            agen_pkg::SZ_16: v[15:0] = gpr[idx][15:0];
            agen_pkg::SZ_32: v[31:0] = gpr[idx];
            agen_pkg::SZ_64: v = mmx[idx];
            default: v = '0;
        endcase
        return v;
    endfunction

    function automatic logic [15:0] seg_read(agen_pkg::seg_file_t seg, logic [2:0] idx);
        logic [15:0] v;
        v = '0;
        if (idx < 3'd6) begin
            v = seg[idx];
        end
        return v;
    endfunction

    function automatic logic [63:0] operand_value(agen_pkg::op_src_e src, logic [2:0] idx,
            agen_pkg::agen_req_t req, agen_pkg::gpr_file_t gpr, agen_pkg::seg_file_t seg,
            agen_pkg::mmx_file_t mmx, logic [31:0] mem_addr);
        logic [63:0] v;
        v = '0;
        case (src)
            agen_pkg::OP_REG: v = sized_view(req.size, idx, gpr, mmx);
            agen_pkg::OP_SEG: v[15:0] = seg_read(seg, idx);
            agen_pkg::OP_MMX: v = mmx[idx];
            agen_pkg::OP_IMM: v[47:0] = req.imm;
            agen_pkg::OP_MEM: v[31:0] = mem_addr;
            default: v = '0;
        endcase
        return v;
    endfunction

    function automatic agen_pkg::agen_out_t expected_out(agen_pkg::agen_req_t req,
            agen_pkg::gpr_file_t gpr, agen_pkg::seg_file_t seg, agen_pkg::mmx_file_t mmx);
        agen_pkg::agen_out_t e;
        logic [31:0] dst_addr;
        logic [31:0] src_base;
        logic [31:0] src_addr;
        // ES:EDI and DS:ESI (or override) in real mode with 32-bit wrap
        dst_addr = ({16'h0, seg[0]} << 4) + gpr[7];
        src_base = {16'h0, req.seg_override_valid ? seg_read(seg, req.seg_override) : seg[3]};
        src_addr = (src_base << 4) + gpr[6];
        e.size = req.size;
        e.op0.value = operand_value(req.op0_src, req.op0_reg, req, gpr, seg, mmx, dst_addr);
        e.op0.is_address = 1'b0;
        e.op1.value = operand_value(req.op1_src, req.op1_reg, req, gpr, seg, mmx, src_addr);
        e.op1.is_address = (req.op1_src == agen_pkg::OP_MEM);
        e.op0_reg = req.op0_reg;
        e.op1_reg = req.op1_reg;
        e.imm = req.imm;
        e.alu_op = req.alu_op;
        e.pc = req.pc;
        e.opcode = req.opcode;
        e.to_sys_controller = (req.op0_src == agen_pkg::OP_SYS);
        return e;
    endfunction

    // mostly valid sizes plus one code that selects nothing
    function automatic agen_pkg::op_size_e pick_size(logic [2:0] sel);
        case (sel)
            3'd0, 3'd4: return agen_pkg::SZ_8;
            3'd1: return agen_pkg::SZ_16;
            3'd2, 3'd6: return agen_pkg::SZ_32;
            3'd3, 3'd5: return agen_pkg::SZ_64;
            default: return agen_pkg::op_size_e'(3'd4);
        endcase
    endfunction

    // called right after each rising edge
    task automatic drive_cycle();
        agen_pkg::agen_req_t req;
        agen_pkg::gpr_file_t gpr;
        agen_pkg::seg_file_t seg;
        agen_pkg::mmx_file_t mmx;
        logic [31:0] rnd;
        logic [31:0] hi;
        if (r_valid && r_ready && !flush) begin
            accepted++;
        end
        // request holds while stalled
        if (!r_valid || r_ready) begin
            rnd = $random(seed);
            hi = $random(seed);
            req.size = pick_size(rnd[2:0]);
            req.op0_src = agen_pkg::op_src_e'(rnd[5:3]);
            req.op1_src = agen_pkg::op_src_e'(rnd[8:6]);
            req.op0_reg = rnd[11:9];
            req.op1_reg = rnd[14:12];
            req.seg_override = agen_pkg::seg_idx_e'(rnd[17:15]);
            req.seg_override_valid = rnd[18];
            req.alu_op = rnd[22:19];
            req.opcode = hi[31:16];
            req.imm = {hi[15:0], $random(seed)};
            req.pc = $random(seed);
            for (int i = 0; i < 8; i++) begin
                gpr[i] = $random(seed);
                mmx[i] = {$random(seed), $random(seed)};
            end
            for (int i = 0; i < 6; i++) begin
                hi = $random(seed);
                seg[i] = hi[15:0];
            end
            r_valid <= (rnd[24:23] != 2'b00);
            r_req <= req;
            r_gpr <= gpr;
            r_seg <= seg;
            r_mmx <= mmx;
        end
        rnd = $random(seed);
        a_ready <= (rnd[1:0] != 2'b00);
        flush <= (rnd[7:3] == 5'd0);
    endtask

    // one-deep stage so the queue never holds more than one item
    always @(posedge clk) begin
        if (!rst_n || flush) begin
            model_q.delete();
        end else begin
            if (a_valid && a_ready) begin
                if (model_q.size() != 0) begin
                    void'(model_q.pop_front());
                end
            end
            if (r_valid && r_ready) begin
                model_q.push_back(expected_out(r_req, r_gpr, r_seg, r_mmx));
            end
        end
        exp_cnt <= model_q.size();
        exp_head <= (model_q.size() != 0) ? model_q[0] : '0;
        acc_d <= rst_n && !flush && r_valid && r_ready;
        stall_d <= rst_n && !flush && a_valid && !a_ready;
        rst_d <= !rst_n || flush;
        prev_out <= a_out;
    end

    assign out_chk = rst_n && a_valid;

    assert property (@(posedge clk) rst_n |-> r_ready == (!a_valid || a_ready))
        else report_mismatch("r_ready", $sampled(r_ready),
                             !$sampled(a_valid) || $sampled(a_ready));
    assert property (@(posedge clk) rst_n |-> a_valid == (exp_cnt != 0))
        else report_mismatch("a_valid", $sampled(a_valid), $sampled(exp_cnt) != 0);
    // accepted at edge N means valid right after edge N
    assert property (@(posedge clk) acc_d |-> a_valid)
        else stop_with_error("accepted item did not appear one cycle later");
    assert property (@(posedge clk) rst_d |-> !a_valid)
        else stop_with_error("a_valid high after reset or flush");
    assert property (@(posedge clk) stall_d |-> a_out == prev_out)
        else report_mismatch("a_out", $sampled(a_out), $sampled(prev_out));
    assert property (@(posedge clk) out_chk |-> a_out.size == exp_head.size)
        else report_mismatch("a_out.size", $sampled(a_out.size), $sampled(exp_head.size));
    assert property (@(posedge clk) out_chk |-> a_out.op0 == exp_head.op0)
        else report_mismatch("a_out.op0", $sampled(a_out.op0), $sampled(exp_head.op0));
    assert property (@(posedge clk) out_chk |-> a_out.op1 == exp_head.op1)
        else report_mismatch("a_out.op1", $sampled(a_out.op1), $sampled(exp_head.op1));
    assert property (@(posedge clk) out_chk |-> a_out.op0_reg == exp_head.op0_reg)
        else report_mismatch("a_out.op0_reg", $sampled(a_out.op0_reg), $sampled(exp_head.op0_reg));
    assert property (@(posedge clk) out_chk |-> a_out.op1_reg == exp_head.op1_reg)
        else report_mismatch("a_out.op1_reg", $sampled(a_out.op1_reg), $sampled(exp_head.op1_reg));
    assert property (@(posedge clk) out_chk |-> a_out.imm == exp_head.imm)
        else report_mismatch("a_out.imm", $sampled(a_out.imm), $sampled(exp_head.imm));
    assert property (@(posedge clk) out_chk |-> a_out.alu_op == exp_head.alu_op)
        else report_mismatch("a_out.alu_op", $sampled(a_out.alu_op), $sampled(exp_head.alu_op));
    assert property (@(posedge clk) out_chk |-> a_out.pc == exp_head.pc)
        else report_mismatch("a_out.pc", $sampled(a_out.pc), $sampled(exp_head.pc));
    assert property (@(posedge clk) out_chk |-> a_out.opcode == exp_head.opcode)
        else report_mismatch("a_out.opcode", $sampled(a_out.opcode), $sampled(exp_head.opcode));
    assert property (@(posedge clk)
            out_chk |-> a_out.to_sys_controller == exp_head.to_sys_controller)
        else report_mismatch("a_out.to_sys_controller", $sampled(a_out.to_sys_controller),
                             $sampled(exp_head.to_sys_controller));

    initial begin
        int cycles;
        rst_n = 1'b0;
        flush = 1'b0;
        r_valid = 1'b0;
        r_req = '0;
        r_gpr = '0;
        r_seg = '0;
        r_mmx = '0;
        a_ready = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        cycles = 0;
        while (accepted < NUM_ITEMS) begin
            @(posedge clk);
            drive_cycle();
            cycles++;
            if (cycles > MAX_CYCLES) begin
                stop_with_error("timeout waiting for requests to be accepted");
            end
        end
        // let the last item leave
        r_valid <= 1'b0;
        a_ready <= 1'b1;
        flush <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (a_valid || exp_cnt != 0) begin
            if (cycles > 20) begin
                stop_with_error("timeout waiting for the stage to drain");
            end
            @(negedge clk);
            cycles++;
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- list.f
+incdir+hdl
hdl/agen_pkg.sv
hdl/reg_size_select.sv
hdl/dest_operand_gen.sv
hdl/src_operand_gen.sv
hdl/agen_pipe_reg.sv
hdl/address_generation_top.sv
testbench/tb_clock.sv
testbench/tb_address_generation.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the address generation testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module tb_address_generation \
    -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
